// File: spu_perm_macros.svh
`ifndef SPU_PERM_MACROS_SVH
`define SPU_PERM_MACROS_SVH

// datapath widths, all fields numbered msb first
`define QW_BITS     128
`define OP_BITS     11
`define ADDR_BITS   7
`define IMM_BITS    18
`define FMT_BITS    3

// stages between register fetch and writeback
`define PERM_DEPTH  4

// instruction formats handled by this pipe
`define FMT_RR      3'd0
`define FMT_RI7     3'd2

// register form opcodes
`define OP_SHLQBI   11'b00111011011
`define OP_SHLQBY   11'b00111011111
`define OP_ROTQBI   11'b00111011000
`define OP_ROTQBY   11'b00111011100
`define OP_GBB      11'b00110110010
`define OP_GBH      11'b00110110001
`define OP_GB       11'b00110110000

// immediate form opcodes
`define OP_SHLQBII  11'b00111111011
`define OP_SHLQBYI  11'b00111111111
`define OP_ROTQBII  11'b00111111000
`define OP_ROTQBYI  11'b00111111100

`endif

// File: spu_perm_pkg.sv
`include "spu_perm_macros.svh"

package spu_perm_pkg;

	// operation class after decode
	// register and immediate forms collapse onto the same class
	typedef enum logic [3:0] {
		PERM_NONE,
		// zero-fill shifts toward bit 0
		PERM_SHL_BIT,
		PERM_SHL_BYTE,
		// rotates toward bit 0
		PERM_ROT_BIT,
		PERM_ROT_BYTE,
		// lsb gathers from bytes, halfwords, words
		PERM_GATHER_B,
		PERM_GATHER_H,
		PERM_GATHER_W
	} perm_op_t;

	// record carried down the stage chain
	// all zero means an empty slot
	typedef struct packed {
		// result value
		logic [0:`QW_BITS-1]   rt;
		// destination register
		logic [0:`ADDR_BITS-1] rt_addr;
		// register file write enable
		logic                  reg_write;
	} wb_rec_t;

endpackage

// File: perm_decode.sv
`timescale 1ns/1ps

`include "spu_perm_macros.svh"

module perm_decode (
	input  logic [0:`OP_BITS-1]   op,
	input  logic [`FMT_BITS-1:0]  format,
	input  logic [0:`IMM_BITS-1]  imm,
	input  logic [0:`QW_BITS-1]   rb,
	input  logic                  branch_taken,
	output spu_perm_pkg::perm_op_t perm_op,
	output logic [4:0]            shift_amt,
	output logic                  kill
);

	import spu_perm_pkg::*;

	// raw decode before the kill override
	perm_op_t   dec_op;
	logic [4:0] dec_amt;

	always_comb begin
		dec_op = PERM_NONE;
		dec_amt = '0;
		if (format == `FMT_RR) begin
			case (op)
				// count from rb word 0 low bits
				`OP_SHLQBI: begin
					dec_op = PERM_SHL_BIT;
					dec_amt = {2'b00, rb[29:31]};
				end
				// five bit count so 16..31 can zero the result
				`OP_SHLQBY: begin
					dec_op = PERM_SHL_BYTE;
					dec_amt = rb[27:31];
				end
				`OP_ROTQBI: begin
					dec_op = PERM_ROT_BIT;
					dec_amt = {2'b00, rb[29:31]};
				end
				// byte rotate wraps at 16
				`OP_ROTQBY: begin
					dec_op = PERM_ROT_BYTE;
					dec_amt = {1'b0, rb[28:31]};
				end
				// gathers take no count
				`OP_GBB: dec_op = PERM_GATHER_B;
				`OP_GBH: dec_op = PERM_GATHER_H;
				`OP_GB:  dec_op = PERM_GATHER_W;
				// nop (op 0) lands here too
				default: dec_op = PERM_NONE;
			endcase
		end
		else if (format == `FMT_RI7) begin
			case (op)
				// only the low field of the immediate counts
				`OP_SHLQBII: begin
					dec_op = PERM_SHL_BIT;
					dec_amt = {2'b00, imm[15:17]};
				end
				`OP_SHLQBYI: begin
					dec_op = PERM_SHL_BYTE;
					dec_amt = {1'b0, imm[14:17]};
				end
				`OP_ROTQBII: begin
					dec_op = PERM_ROT_BIT;
					dec_amt = {2'b00, imm[15:17]};
				end
				`OP_ROTQBYI: begin
					dec_op = PERM_ROT_BYTE;
					dec_amt = {1'b0, imm[14:17]};
				end
				default: dec_op = PERM_NONE;
			endcase
		end
	end

	// nop, unknown pair or squashed by a taken branch
	assign kill = branch_taken || (dec_op == PERM_NONE);

	// killed slots leave decode as a clean none
	assign perm_op = kill ? PERM_NONE : dec_op;
	assign shift_amt = kill ? 5'd0 : dec_amt;

endmodule

// File: perm_datapath.sv
`timescale 1ns/1ps

`include "spu_perm_macros.svh"

module perm_datapath (
	input  spu_perm_pkg::perm_op_t perm_op,
	input  logic [4:0]            shift_amt,
	input  logic                  kill,
	input  logic [0:`QW_BITS-1]   ra,
	input  logic [0:`ADDR_BITS-1] rt_addr,
	input  logic                  reg_write,
	output logic [0:`QW_BITS-1]   stage_value,
	output logic [0:`ADDR_BITS-1] stage_addr,
	output logic                  stage_write
);

	import spu_perm_pkg::*;

	// gathered bits end at bit 31 of word 0
	localparam int GB_END = 32;
	localparam int N_BYTES = `QW_BITS / 8;
	localparam int N_HALVES = `QW_BITS / 16;
	localparam int N_WORDS = `QW_BITS / 32;

	// byte counts scaled to bits
	logic [7:0] shl_byte_amt;
	logic [6:0] rot_byte_amt;

	// ra repeated so a rotate is a plain part select
	logic [0:2*`QW_BITS-1] ra_twice;

	// one candidate per operation class
	logic [0:`QW_BITS-1] shl_bit;
	logic [0:`QW_BITS-1] shl_byte;
	logic [0:`QW_BITS-1] rot_bit;
	logic [0:`QW_BITS-1] rot_byte;
	logic [0:`QW_BITS-1] gather_b;
	logic [0:`QW_BITS-1] gather_h;
	logic [0:`QW_BITS-1] gather_w;
	logic [0:`QW_BITS-1] result;

	assign shl_byte_amt = {shift_amt, 3'b000};
	assign rot_byte_amt = {shift_amt[3:0], 3'b000};
	assign ra_twice = {ra, ra};

	// left shift moves bits toward index 0 with this numbering
	assign shl_bit = ra << shift_amt;

	// 16 bytes or more shifts everything out
	assign shl_byte = shift_amt[4] ? '0 : (ra << shl_byte_amt);

	// window into the doubled vector starting at the count
	assign rot_bit = ra_twice[shift_amt +: `QW_BITS];
	assign rot_byte = ra_twice[rot_byte_amt +: `QW_BITS];

	always_comb begin
		gather_b = '0;
		gather_h = '0;
		gather_w = '0;
		// byte 0 lsb lands in the highest order slot
		for (int k = 0; k < N_BYTES; k++) begin
			gather_b[GB_END - N_BYTES + k] = ra[8*k + 7];
		end
		// halfword lsbs into bits 24..31
		for (int k = 0; k < N_HALVES; k++) begin
			gather_h[GB_END - N_HALVES + k] = ra[16*k + 15];
		end
		// word lsbs into bits 28..31
		for (int k = 0; k < N_WORDS; k++) begin
			gather_w[GB_END - N_WORDS + k] = ra[32*k + 31];
		end
	end

	// result select by operation class
	always_comb begin
		case (perm_op)
			PERM_SHL_BIT:  result = shl_bit;
			PERM_SHL_BYTE: result = shl_byte;
			PERM_ROT_BIT:  result = rot_bit;
			PERM_ROT_BYTE: result = rot_byte;
			PERM_GATHER_B: result = gather_b;
			PERM_GATHER_H: result = gather_h;
			PERM_GATHER_W: result = gather_w;
			default:       result = '0;
		endcase
	end

	// killed slot becomes an all zero record
	assign stage_value = kill ? '0 : result;
	assign stage_addr = kill ? '0 : rt_addr;
	// write flag passes through even when the value is unused
	assign stage_write = kill ? 1'b0 : reg_write;

endmodule

// File: pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
	// record carried by the register
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t d,
	output payload_t q
);

	// one clock of delay, no enable
	// reset empties the slot so a zero record reads as a bubble
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end
		else begin
			q <= d;
		end
	end

endmodule

// File: spu_perm_top.sv
`timescale 1ns/1ps

`include "spu_perm_macros.svh"

module spu_perm_top (
	input  logic                  clk,
	input  logic                  reset,
	// register fetch / forward stage
	input  logic [0:`OP_BITS-1]   op,
	input  logic [`FMT_BITS-1:0]  format,
	input  logic [0:`ADDR_BITS-1] rt_addr,
	input  logic [0:`QW_BITS-1]   ra,
	input  logic [0:`QW_BITS-1]   rb,
	input  logic [0:`IMM_BITS-1]  imm,
	input  logic                  reg_write,
	input  logic                  branch_taken,
	// writeback stage
	output logic [0:`QW_BITS-1]   rt_wb,
	output logic [0:`ADDR_BITS-1] rt_addr_wb,
	output logic                  reg_write_wb
);

	import spu_perm_pkg::*;

	// decode to datapath
	perm_op_t   perm_op;
	logic [4:0] shift_amt;
	logic       kill;

	// record entering stage 0
	logic [0:`QW_BITS-1]   stage_value;
	logic [0:`ADDR_BITS-1] stage_addr;
	logic                  stage_write;

	// stage_rec[0] is combinational, the rest are register outputs
	wb_rec_t stage_rec [0:`PERM_DEPTH];

	perm_decode u_decode (
		.op(op),
		.format(format),
		.imm(imm),
		.rb(rb),
		.branch_taken(branch_taken),
		.perm_op(perm_op),
		.shift_amt(shift_amt),
		.kill(kill)
	);

	perm_datapath u_datapath (
		.perm_op(perm_op),
		.shift_amt(shift_amt),
		.kill(kill),
		.ra(ra),
		.rt_addr(rt_addr),
		.reg_write(reg_write),
		.stage_value(stage_value),
		.stage_addr(stage_addr),
		.stage_write(stage_write)
	);

	assign stage_rec[0] = '{rt: stage_value, rt_addr: stage_addr, reg_write: stage_write};

	// fixed latency chain, no stall
	genvar s;
	generate
		for (s = 0; s < `PERM_DEPTH; s++) begin : g_stage
			pipe_stage #(.payload_t(wb_rec_t)) u_stage (
				.clk(clk),
				.reset(reset),
				.d(stage_rec[s]),
				.q(stage_rec[s+1])
			);
		end
	endgenerate

	// last stage drives writeback directly
	assign rt_wb = stage_rec[`PERM_DEPTH].rt;
	assign rt_addr_wb = stage_rec[`PERM_DEPTH].rt_addr;
	assign reg_write_wb = stage_rec[`PERM_DEPTH].reg_write;

endmodule

// File: tb_spu_perm_top.sv
`timescale 1ns/1ps

`include "spu_perm_macros.svh"

module tb_spu_perm_top;

	import spu_perm_pkg::*;

	// issue cycles per test without the drains
	localparam int RESET_CYCLES = 4;
	localparam int N_REG = 24;
	localparam int N_IMM = 16;
	localparam int N_GATHER = 12;
	localparam int N_KILL = 9;
	localparam int N_WFLAG = 8;
	localparam int N_TESTS = 6;
	// every issue and drain plus pipe depth and margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 1 + N_REG + N_IMM + N_GATHER + N_KILL
		+ N_WFLAG + N_TESTS * `PERM_DEPTH + `PERM_DEPTH + 20;
	localparam wb_rec_t EMPTY_REC = '0;

	logic                  clk;
	logic                  reset;
	logic [0:`OP_BITS-1]   op;
	logic [`FMT_BITS-1:0]  format;
	logic [0:`ADDR_BITS-1] rt_addr;
	logic [0:`QW_BITS-1]   ra;
	logic [0:`QW_BITS-1]   rb;
	logic [0:`IMM_BITS-1]  imm;
	logic                  reg_write;
	logic                  branch_taken;
	logic [0:`QW_BITS-1]   rt_wb;
	logic [0:`ADDR_BITS-1] rt_addr_wb;
	logic                  reg_write_wb;

	int seed;
	int cycle_count;
	int check_count;
	int fail_count;
	int tests_passed;
	int tests_failed;

	// expected record for what is on the inputs right now
	wb_rec_t cur_exp;
	// expected stage contents with the writeback stage at the front
	wb_rec_t exp_pipe[$];

	spu_perm_top UUT (
		.clk(clk),
		.reset(reset),
		.op(op),
		.format(format),
		.rt_addr(rt_addr),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.reg_write(reg_write),
		.branch_taken(branch_taken),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// expected writeback record with bit 0 as the msb
	function automatic wb_rec_t model_record(
		input logic [0:`OP_BITS-1]   m_op,
		input logic [`FMT_BITS-1:0]  m_fmt,
		input logic [0:`ADDR_BITS-1] m_addr,
		input logic [0:`QW_BITS-1]   m_ra,
		input logic [0:`QW_BITS-1]   m_rb,
		input logic [0:`IMM_BITS-1]  m_imm,
		input logic                  m_wr,
		input logic                  m_br
	);
		// kind is 0 for none, 1 for a zero fill shift, 2 for a rotate and 3 for a gather
		int kind;
		int amt;
		int grain;
		int n;
		wb_rec_t rec;
		kind = 0;
		amt = 0;
		grain = 0;
		rec = '0;
		if (m_fmt == `FMT_RR) begin
			case (m_op)
				`OP_SHLQBI, `OP_SHLQBY: kind = 1;
				`OP_ROTQBI, `OP_ROTQBY: kind = 2;
				`OP_GBB: grain = 8;
				`OP_GBH: grain = 16;
				`OP_GB: grain = 32;
				default: kind = 0;
			endcase
			// counts in bits with byte counts scaled by eight
			case (m_op)
				`OP_SHLQBI, `OP_ROTQBI: amt = int'(m_rb[29:31]);
				`OP_SHLQBY: amt = 8 * int'(m_rb[27:31]);
				`OP_ROTQBY: amt = 8 * int'(m_rb[28:31]);
				default: amt = 0;
			endcase
		end
		else if (m_fmt == `FMT_RI7) begin
			case (m_op)
				`OP_SHLQBII, `OP_SHLQBYI: kind = 1;
				`OP_ROTQBII, `OP_ROTQBYI: kind = 2;
				default: kind = 0;
			endcase
			case (m_op)
				`OP_SHLQBII, `OP_ROTQBII: amt = int'(m_imm[15:17]);
				`OP_SHLQBYI, `OP_ROTQBYI: amt = 8 * int'(m_imm[14:17]);
				default: amt = 0;
			endcase
		end
		if (grain != 0) kind = 3;
		// squashed by a taken branch
		if (m_br) kind = 0;
		// shift of 128 bits or more leaves all zeros
		for (int i = 0; i < `QW_BITS; i++) begin
			if (kind == 1 && i + amt < `QW_BITS) rec.rt[i] = m_ra[i + amt];
			if (kind == 2) rec.rt[i] = m_ra[(i + amt) % `QW_BITS];
		end
		if (kind == 3) begin
			n = `QW_BITS / grain;
			// element k lsb into bit 32-n+k
			for (int k = 0; k < n; k++) begin
				rec.rt[32 - n + k] = m_ra[grain * k + grain - 1];
			end
		end
		if (kind != 0) begin
			rec.rt_addr = m_addr;
			rec.reg_write = m_wr;
		end
		return rec;
	endfunction

	function automatic logic [0:`QW_BITS-1] rand_qw();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic logic [0:`ADDR_BITS-1] rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return r[6:0];
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count++;
		if (actual !== expected) begin
			fail_count++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// one instruction driven just after the edge
	task automatic issue(
		input logic [0:`OP_BITS-1]   i_op,
		input logic [`FMT_BITS-1:0]  i_fmt,
		input logic [0:`ADDR_BITS-1] i_addr,
		input logic [0:`QW_BITS-1]   i_ra,
		input logic [0:`QW_BITS-1]   i_rb,
		input logic [0:`IMM_BITS-1]  i_imm,
		input logic                  i_wr,
		input logic                  i_br
	);
		@(posedge clk);
		#5;
		op = i_op;
		format = i_fmt;
		rt_addr = i_addr;
		ra = i_ra;
		rb = i_rb;
		imm = i_imm;
		reg_write = i_wr;
		branch_taken = i_br;
		cur_exp = model_record(i_op, i_fmt, i_addr, i_ra, i_rb, i_imm, i_wr, i_br);
	endtask

	task automatic issue_idle();
		issue('0, `FMT_RR, '0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	// bubbles until the last result has been compared
	task automatic drain_pipe();
		repeat (`PERM_DEPTH) issue_idle();
		@(negedge clk);
		#1;
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before) begin
			tests_passed++;
			$display("test %s done, no mismatches", name);
		end
		else begin
			tests_failed++;
			$display("test %s done, %0d mismatches", name, fail_count - fails_before);
		end
	endtask

	// stage model shifted on the same edge the DUT samples
	always @(posedge clk) begin
		if (reset) begin
			exp_pipe.delete();
			for (int s = 0; s < `PERM_DEPTH; s++) begin
				exp_pipe.push_back(EMPTY_REC);
			end
		end
		else if (exp_pipe.size() > 0) begin
			exp_pipe.push_back(cur_exp);
			void'(exp_pipe.pop_front());
		end
	end

	// outputs settled half a period after the edge
	always @(negedge clk) begin
		if (exp_pipe.size() == `PERM_DEPTH) begin
			check_value("rt_wb", exp_pipe[0].rt, rt_wb);
			check_value("rt_addr_wb", 128'(exp_pipe[0].rt_addr), 128'(rt_addr_wb));
			check_value("reg_write_wb", 128'(exp_pipe[0].reg_write), 128'(reg_write_wb));
		end
	end

	task automatic test_reset();
		int fails_before;
		fails_before = fail_count;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;
		// cleared chain reads as an empty slot
		check_value("rt_wb", '0, rt_wb);
		check_value("reg_write_wb", '0, 128'(reg_write_wb));
		issue(`OP_ROTQBI, `FMT_RR, 7'd9, rand_qw(), rand_qw(), '0, 1'b1, 1'b0);
		// write flag stays low until the fourth edge
		for (int k = 0; k < `PERM_DEPTH; k++) begin
			issue_idle();
			check_value("reg_write_wb", (k == `PERM_DEPTH - 1) ? 128'd1 : 128'd0,
				128'(reg_write_wb));
		end
		@(negedge clk);
		#1;
		report_test("reset", fails_before);
	endtask

	task automatic test_reg_shifts();
		logic [0:`OP_BITS-1] ops [0:3];
		logic [0:`QW_BITS-1] count;
		int fails_before;
		ops = '{`OP_SHLQBI, `OP_SHLQBY, `OP_ROTQBI, `OP_ROTQBY};
		fails_before = fail_count;
		// back to back so four are in flight
		for (int i = 0; i < N_REG; i++) begin
			count = rand_qw();
			// byte shifts of 16 and 31 force a zero result
			if (i == 1) count[27:31] = 5'd16;
			if (i == 5) count[27:31] = 5'd31;
			issue(ops[i % 4], `FMT_RR, rand_addr(), rand_qw(), count, '0, 1'b1, 1'b0);
		end
		drain_pipe();
		report_test("register shifts", fails_before);
	endtask

	task automatic test_imm_shifts();
		logic [0:`OP_BITS-1] ops [0:3];
		logic [31:0] r;
		int fails_before;
		ops = '{`OP_SHLQBII, `OP_SHLQBYI, `OP_ROTQBII, `OP_ROTQBYI};
		fails_before = fail_count;
		for (int i = 0; i < N_IMM; i++) begin
			r = $random(seed);
			// upper immediate bits are all set and must be ignored
			issue(ops[i % 4], `FMT_RI7, rand_addr(), rand_qw(), rand_qw(),
				{14'h3fff, r[3:0]}, 1'b1, 1'b0);
		end
		drain_pipe();
		report_test("immediate shifts", fails_before);
	endtask

	task automatic test_gathers();
		logic [0:`OP_BITS-1] ops [0:2];
		logic [0:`QW_BITS-1] pats [0:3];
		int fails_before;
		ops = '{`OP_GBB, `OP_GBH, `OP_GB};
		pats = '{{`QW_BITS{1'b1}}, {16{8'h01}}, 128'h0123456789abcdeffedcba9876543210,
			rand_qw()};
		fails_before = fail_count;
		for (int i = 0; i < N_GATHER; i++) begin
			issue(ops[i / 4], `FMT_RR, rand_addr(), pats[i % 4], rand_qw(), '0, 1'b1, 1'b0);
		end
		drain_pipe();
		report_test("gathers", fails_before);
	endtask

	task automatic test_kills();
		int fails_before;
		fails_before = fail_count;
		// each killed slot sits between two live ones
		issue(`OP_SHLQBI, `FMT_RR, rand_addr(), rand_qw(), rand_qw(), '0, 1'b1, 1'b0);
		issue(11'd0, `FMT_RR, 7'h55, rand_qw(), rand_qw(), '1, 1'b1, 1'b0);
		issue(`OP_ROTQBY, `FMT_RR, rand_addr(), rand_qw(), rand_qw(), '0, 1'b1, 1'b0);
		issue(11'h7ff, `FMT_RR, 7'h2a, rand_qw(), rand_qw(), '1, 1'b1, 1'b0);
		issue(`OP_GBB, `FMT_RR, rand_addr(), rand_qw(), rand_qw(), '0, 1'b1, 1'b0);
		// valid register opcode under format 1
		issue(`OP_SHLQBI, 3'd1, 7'h7f, rand_qw(), rand_qw(), '1, 1'b1, 1'b0);
		issue(`OP_SHLQBYI, `FMT_RI7, rand_addr(), rand_qw(), rand_qw(), 18'h00005, 1'b1, 1'b0);
		issue(`OP_ROTQBI, `FMT_RR, 7'h11, rand_qw(), rand_qw(), '0, 1'b1, 1'b1);
		issue(`OP_ROTQBII, `FMT_RI7, rand_addr(), rand_qw(), rand_qw(), 18'h00003, 1'b1, 1'b0);
		drain_pipe();
		report_test("kills", fails_before);
	endtask

	task automatic test_write_flag();
		logic [0:`OP_BITS-1] ops [0:3];
		int fails_before;
		ops = '{`OP_ROTQBY, `OP_GBH, `OP_SHLQBI, `OP_ROTQBI};
		fails_before = fail_count;
		// value still computed when the write is off
		for (int i = 0; i < N_WFLAG; i++) begin
			issue(ops[i % 4], `FMT_RR, rand_addr(), rand_qw(), rand_qw(), '0,
				(i % 2 == 0) ? 1'b0 : 1'b1, 1'b0);
		end
		drain_pipe();
		report_test("write flag", fails_before);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		seed = 52148;
		check_count = 0;
		fail_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset = 1'b1;
		op = '0;
		format = '0;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		imm = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		cur_exp = EMPTY_REC;
		test_reset();
		test_reg_shifts();
		test_imm_shifts();
		test_gathers();
		test_kills();
		test_write_flag();
		$display("tests passed %0d, tests failed %0d, %0d checks, %0d mismatches",
			tests_passed, tests_failed, check_count, fail_count);
		if (tests_failed == 0 && fail_count == 0) begin
			$display("Result: PASSED");
		end
		else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: spu_perm_top.f
+incdir+.
spu_perm_pkg.sv
perm_decode.sv
perm_datapath.sv
pipe_stage.sv
spu_perm_top.sv
tb_spu_perm_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the permute pipe testbench with Verilator

TOP=tb_spu_perm_top
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f spu_perm_top.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides, not the exit status alone
if grep -q "^Result: PASSED$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
